// ==== hw/simd_alu_pkg.sv ====
`default_nettype none

package simd_alu_pkg;

    // ****************************************
    // sizes
    // ****************************************
    localparam int DATA_W    = 64;   // full register
    localparam int LANE_W    = 16;   // one half-word lane
    localparam int NUM_LANES = DATA_W / LANE_W;

    // opcode values as seen on the instruction field
    typedef enum logic [5:0] {
        OP_VAND   = 6'd1,
        OP_VOR    = 6'd2,
        OP_VXOR   = 6'd3,
        OP_VNOT   = 6'd4,
        OP_VMOV   = 6'd5,
        OP_VADD   = 6'd6,
        OP_VSUB   = 6'd7,
        OP_VMULEU = 6'd8,   // even bytes
        OP_VMULOU = 6'd9,   // odd bytes
        OP_VSLL   = 6'd10,
        OP_VSRL   = 6'd11,
        OP_VSRA   = 6'd12,  // never implemented
        OP_VRTTH  = 6'd13,
        OP_VDIV   = 6'd14,  // no divider here
        OP_VMOD   = 6'd15,
        OP_VSQEU  = 6'd16,
        OP_VSQOU  = 6'd17,
        OP_VSQRT  = 6'd18,
        OP_VNOP   = 6'd23
    } alu_op_e;

    // element width, ww field
    typedef enum logic [1:0] {
        W_BYTE   = 2'b00,
        W_HALF   = 2'b01,
        W_WORD   = 2'b10,
        W_DOUBLE = 2'b11
    } width_e;

    // what a lane actually does, squares fold into the multiplies
    typedef enum logic [3:0] {
        FN_AND, FN_OR, FN_XOR, FN_NOT, FN_MOV,
        FN_ADD, FN_SUB, FN_SLL, FN_SRL, FN_RTTH,
        FN_MUL_EVEN, FN_MUL_ODD
    } lane_fn_e;

    typedef logic [0:LANE_W-1] lane_word_t;  // bit 0 is msb

    typedef struct packed {
        logic     valid;
        lane_fn_e fn;
        logic     half;     // half-word elements, else bytes
        logic     illegal;  // result gets forced to zero
    } lane_ctrl_t;

    typedef struct packed {
        logic [0:DATA_W-1] a;
        logic [0:DATA_W-1] b;
    } opnd_t;

endpackage

`default_nettype wire

// ==== hw/simd_op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_op_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  simd_alu_pkg::alu_op_e   alu_op,
    input  simd_alu_pkg::width_e    width,
    input  simd_alu_pkg::opnd_t     opnd,
    output simd_alu_pkg::lane_ctrl_t ctrl,
    output simd_alu_pkg::opnd_t     lane_opnd
);
    import simd_alu_pkg::*;

    lane_fn_e fn_d;
    logic     known;      // opcode is one we build
    logic     width_dep;  // result depends on element width
    logic     mul_op;     // multiply or square, bytes only
    logic     square;     // b comes from a
    logic     wide;       // word or double requested
    logic     illegal_d;
    opnd_t    opnd_d;

    // ****************************************
    // opcode to lane function
    // ****************************************
    always_comb begin
        fn_d      = FN_AND;
        known     = 1'b1;
        width_dep = 1'b0;
        mul_op    = 1'b0;
        square    = 1'b0;
        case (alu_op)
            OP_VAND:   fn_d = FN_AND;
            OP_VOR:    fn_d = FN_OR;
            OP_VXOR:   fn_d = FN_XOR;
            OP_VNOT:   fn_d = FN_NOT;
            OP_VMOV:   fn_d = FN_MOV;
            OP_VADD: begin
                fn_d      = FN_ADD;
                width_dep = 1'b1;
            end
            OP_VSUB: begin
                fn_d      = FN_SUB;
                width_dep = 1'b1;
            end
            OP_VSLL: begin
                fn_d      = FN_SLL;
                width_dep = 1'b1;
            end
            OP_VSRL: begin
                fn_d      = FN_SRL;
                width_dep = 1'b1;
            end
            OP_VRTTH: begin
                fn_d      = FN_RTTH;
                width_dep = 1'b1;
            end
            OP_VMULEU, OP_VSQEU: begin
                fn_d      = FN_MUL_EVEN;
                width_dep = 1'b1;
                mul_op    = 1'b1;
                square    = (alu_op == OP_VSQEU);
            end
            OP_VMULOU, OP_VSQOU: begin
                fn_d      = FN_MUL_ODD;
                width_dep = 1'b1;
                mul_op    = 1'b1;
                square    = (alu_op == OP_VSQOU);
            end
            OP_VSRA, OP_VDIV, OP_VMOD, OP_VSQRT, OP_VNOP: known = 1'b0;
            default:   known = 1'b0;  // unused codes, ld/st/branch
        endcase
    end

    always_comb begin
        case (width)
            W_BYTE, W_HALF:   wide = 1'b0;
            W_WORD, W_DOUBLE: wide = 1'b1;
        endcase
    end

    // all legality is settled here, later stages only carry the flag
    assign illegal_d = !known || (width_dep && wide) || (mul_op && width != W_BYTE);

    assign opnd_d.a = opnd.a;
    assign opnd_d.b = square ? opnd.a : opnd.b;  // square = a times a

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else begin
            ctrl.valid   <= in_valid;
            ctrl.fn      <= fn_d;
            ctrl.half    <= (width == W_HALF);
            ctrl.illegal <= in_valid && illegal_d;  // idle cycles stay clean
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            lane_opnd <= opnd_d;  // hold operands while idle
        end
    end

    // a legal multiply reaching the lanes is always byte wide
    a_mul_byte_only: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.valid && !ctrl.illegal && ctrl.fn inside {FN_MUL_EVEN, FN_MUL_ODD}
            |-> !ctrl.half);

endmodule

`default_nettype wire

// ==== hw/simd_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_lane (
    input  logic                     clk,
    input  logic                     rst_n,
    input  simd_alu_pkg::lane_ctrl_t ctrl_in,
    input  simd_alu_pkg::lane_word_t a,
    input  simd_alu_pkg::lane_word_t b,
    output simd_alu_pkg::lane_ctrl_t ctrl_out,
    output simd_alu_pkg::lane_word_t y
);
    import simd_alu_pkg::*;

    lane_word_t sum_w;
    lane_word_t diff_w;
    lane_word_t sll_w;
    lane_word_t srl_w;
    lane_word_t rtth_w;
    lane_word_t mul_even_w;
    lane_word_t mul_odd_w;
    lane_word_t y_d;

    // ****************************************
    // element-wise arithmetic
    // ****************************************
    // byte halves are 8 bit wide each, so carries stop at the byte edge
    always_comb begin
        if (ctrl_in.half) begin
            sum_w  = a + b;
            diff_w = a - b;
        end else begin
            sum_w  = {a[0:7] + b[0:7], a[8:15] + b[8:15]};
            diff_w = {a[0:7] - b[0:7], a[8:15] - b[8:15]};
        end
    end

    // shift amount = low bits of the same element of b
    always_comb begin
        if (ctrl_in.half) begin
            sll_w = a << b[12:15];  // 0..15
            srl_w = a >> b[12:15];
        end else begin
            sll_w = {a[0:7] << b[5:7], a[8:15] << b[13:15]};  // 0..7 per byte
            srl_w = {a[0:7] >> b[5:7], a[8:15] >> b[13:15]};
        end
    end

    // rotate by half an element
    always_comb begin
        if (ctrl_in.half) begin
            rtth_w = {a[8:15], a[0:7]};                    // swap bytes
        end else begin
            rtth_w = {a[4:7], a[0:3], a[12:15], a[8:11]};  // swap nibbles
        end
    end

    // element 0 of the lane is the upper byte, so it is the even one
    assign mul_even_w = a[0:7] * b[0:7];    // full 16 bit product
    assign mul_odd_w  = a[8:15] * b[8:15];

    // ****************************************
    // result select
    // ****************************************
    always_comb begin
        case (ctrl_in.fn)
            FN_AND:      y_d = a & b;
            FN_OR:       y_d = a | b;
            FN_XOR:      y_d = a ^ b;
            FN_NOT:      y_d = ~a;
            FN_MOV:      y_d = a;
            FN_ADD:      y_d = sum_w;
            FN_SUB:      y_d = diff_w;
            FN_SLL:      y_d = sll_w;
            FN_SRL:      y_d = srl_w;
            FN_RTTH:     y_d = rtth_w;
            FN_MUL_EVEN: y_d = mul_even_w;
            FN_MUL_ODD:  y_d = mul_odd_w;
            default:     y_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_out <= '0;
        end else begin
            ctrl_out <= ctrl_in;  // control rides along with the data
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_in.valid) begin
            y <= y_d;
        end
    end

    // merge trusts illegal without looking at valid
    a_illegal_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_out.illegal |-> ctrl_out.valid);

endmodule

`default_nettype wire

// ==== hw/simd_result_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_result_merge (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  simd_alu_pkg::lane_ctrl_t                             ctrl,
    input  simd_alu_pkg::lane_word_t [0:simd_alu_pkg::NUM_LANES-1] lane_y,
    output logic                                                 out_valid,
    output logic [0:simd_alu_pkg::DATA_W-1]                      result,
    output logic                                                 illegal
);
    import simd_alu_pkg::*;

    logic [0:DATA_W-1] merged;

    // ****************************************
    // gather lanes, lane 0 lands on top
    // ****************************************
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            merged[k*LANE_W +: LANE_W] = lane_y[k];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= ctrl.valid;
            illegal   <= ctrl.illegal;  // only ever set on a valid op
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.valid) begin
            result <= ctrl.illegal ? '0 : merged;  // bad ops read as zero
        end
    end

    // a flagged result never leaks lane data
    a_illegal_zero: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> result == '0);

endmodule

`default_nettype wire

// ==== hw/simd_alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_alu_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  simd_alu_pkg::alu_op_e           alu_op,
    input  simd_alu_pkg::width_e            width,
    input  simd_alu_pkg::opnd_t             opnd,
    output logic                            out_valid,
    output logic [0:simd_alu_pkg::DATA_W-1] result,
    output logic                            illegal
);
    import simd_alu_pkg::*;

    lane_ctrl_t                 ctrl;        // decode -> all lanes
    opnd_t                      lane_opnd;
    lane_ctrl_t                 lane0_ctrl;  // lane 0 copy feeds the merge
    lane_word_t [0:NUM_LANES-1] lane_y;

    // ****************************************
    // stage 1 decode, 2 lanes, 3 merge
    // ****************************************
    simd_op_decode simd_op_decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .alu_op    (alu_op),
        .width     (width),
        .opnd      (opnd),
        .ctrl      (ctrl),
        .lane_opnd (lane_opnd)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        if (k == 0) begin : g_head
            simd_lane simd_lane_i (
                .clk      (clk),
                .rst_n    (rst_n),
                .ctrl_in  (ctrl),
                .a        (lane_opnd.a[k*LANE_W +: LANE_W]),  // msb slice
                .b        (lane_opnd.b[k*LANE_W +: LANE_W]),
                .ctrl_out (lane0_ctrl),
                .y        (lane_y[k])
            );
        end else begin : g_rest
            simd_lane simd_lane_i (
                .clk      (clk),
                .rst_n    (rst_n),
                .ctrl_in  (ctrl),
                .a        (lane_opnd.a[k*LANE_W +: LANE_W]),
                .b        (lane_opnd.b[k*LANE_W +: LANE_W]),
                .ctrl_out (),  // same as lane 0
                .y        (lane_y[k])
            );
        end
    end

    simd_result_merge simd_result_merge_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (lane0_ctrl),
        .lane_y    (lane_y),
        .out_valid (out_valid),
        .result    (result),
        .illegal   (illegal)
    );

endmodule

`default_nettype wire

// ==== test/simd_alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module simd_alu_tb;
    import simd_alu_pkg::*;

    localparam int NUM_RAND = 200;   // random sweep length
    localparam int LATENCY  = 3;     // decode, lane, merge
    localparam logic [63:0] ALL1 = 64'hFFFF_FFFF_FFFF_FFFF;
    localparam logic [63:0] PAT  = 64'h0101_0101_0101_0101;

    typedef struct packed {
        alu_op_e     op;
        width_e      w;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] y;
        logic        bad;   // illegal expected
    } vec_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    alu_op_e     alu_op;
    width_e      width;
    opnd_t       opnd;
    logic        out_valid;
    logic [63:0] result;    // element 0 in the top bits
    logic        illegal;

    vec_t        vec_tab[$];
    logic [64:0] exp_q[$];  // {illegal, result}
    int          due_q[$];  // negedge count when the result shows
    int          cycle = 0;
    int          max_cycles;
    int          errors = 0;

    simd_alu_top simd_alu_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .alu_op    (alu_op),
        .width     (width),
        .opnd      (opnd),
        .out_valid (out_valid),
        .result    (result),
        .illegal   (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // ****************************************
    // reference behaviour
    // ****************************************
    function automatic logic [7:0] byte_elem_op(input alu_op_e op, input logic [7:0] x,
                                                input logic [7:0] s);
        case (op)
            OP_VADD: return x + s;
            OP_VSUB: return x - s;
            OP_VSLL: return x << s[2:0];   // 0..7
            OP_VSRL: return x >> s[2:0];
            default: return {x[3:0], x[7:4]};  // nibble swap
        endcase
    endfunction

    function automatic logic [15:0] half_elem_op(input alu_op_e op, input logic [15:0] x,
                                                 input logic [15:0] s);
        case (op)
            OP_VADD: return x + s;
            OP_VSUB: return x - s;
            OP_VSLL: return x << s[3:0];   // 0..15
            OP_VSRL: return x >> s[3:0];
            default: return {x[7:0], x[15:8]};  // byte swap
        endcase
    endfunction

    function automatic logic [64:0] model_result(input alu_op_e op, input width_e w,
                                                 input logic [63:0] a, input logic [63:0] b);
        logic [63:0] y;
        logic [7:0]  ea;
        logic [7:0]  eb;
        logic        bad;
        logic        odd;
        logic        sq;
        int          base;
        y   = '0;
        bad = 1'b0;
        odd = (op == OP_VMULOU) || (op == OP_VSQOU);
        sq  = (op == OP_VSQEU) || (op == OP_VSQOU);
        case (op)
            OP_VAND: y = a & b;
            OP_VOR:  y = a | b;
            OP_VXOR: y = a ^ b;
            OP_VNOT: y = ~a;
            OP_VMOV: y = a;
            OP_VADD, OP_VSUB, OP_VSLL, OP_VSRL, OP_VRTTH: begin
                bad = (w == W_WORD) || (w == W_DOUBLE);
                for (int i = 0; i < 8 && w == W_BYTE; i++) begin
                    y[63-8*i -: 8] = byte_elem_op(op, a[63-8*i -: 8], b[63-8*i -: 8]);
                end
                for (int i = 0; i < 4 && w == W_HALF; i++) begin
                    y[63-16*i -: 16] = half_elem_op(op, a[63-16*i -: 16],
                                                    b[63-16*i -: 16]);
                end
            end
            OP_VMULEU, OP_VMULOU, OP_VSQEU, OP_VSQOU: begin
                bad = (w != W_BYTE);
                for (int i = 0; i < 4; i++) begin
                    base = 63 - 16*i - (odd ? 8 : 0);  // even byte is the upper one
                    ea   = a[base -: 8];
                    eb   = sq ? ea : b[base -: 8];
                    y[63-16*i -: 16] = {8'h00, ea} * {8'h00, eb};
                end
            end
            default: bad = 1'b1;  // div, mod, sqrt, sra, nop, unused codes
        endcase
        if (bad) begin
            y = '0;
        end
        return {bad, y};
    endfunction

    // ****************************************
    // stimulus
    // ****************************************
    task automatic add_vec(input alu_op_e op, input width_e w, input logic [63:0] a,
                           input logic [63:0] b, input logic [63:0] y, input logic bad);
        vec_tab.push_back('{op, w, a, b, y, bad});
    endtask

    task automatic issue_op(input alu_op_e op, input width_e w, input logic [63:0] a,
                            input logic [63:0] b, input logic [63:0] y, input logic bad);
        @(posedge clk);
        in_valid <= 1'b1;
        alu_op   <= op;
        width    <= w;
        opnd.a   <= a;
        opnd.b   <= b;
        exp_q.push_back({bad, y});
        due_q.push_back(cycle + 1 + LATENCY);  // sampled on the next edge
    endtask

    task automatic go_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic fill_table;
        add_vec(OP_VAND,  W_BYTE,   64'hF0F0_FF00_1234_5678, 64'hFF00_0FF0_F0F0_0F0F,
                64'hF000_0F00_1030_0608, 1'b0);
        add_vec(OP_VOR,   W_DOUBLE, 64'hF0F0_FF00_1234_5678, 64'hFF00_0FF0_F0F0_0F0F,
                64'hFFF0_FFF0_F2F4_5F7F, 1'b0);
        add_vec(OP_VXOR,  W_WORD,   64'hF0F0_FF00_1234_5678, 64'hFF00_0FF0_F0F0_0F0F,
                64'h0FF0_F0F0_E2C4_5977, 1'b0);
        add_vec(OP_VNOT,  W_HALF,   64'h0123_4567_89AB_CDEF, '0, 64'hFEDC_BA98_7654_3210, 1'b0);
        add_vec(OP_VMOV,  W_DOUBLE, 64'hDEAD_BEEF_CAFE_F00D, PAT, 64'hDEAD_BEEF_CAFE_F00D, 1'b0);
        // carries and borrows stay inside the element
        add_vec(OP_VADD,  W_BYTE,   64'hFF01_7F80_0000_1234, 64'h0101_0180_0000_0101,
                64'h0002_8000_0000_1335, 1'b0);
        add_vec(OP_VADD,  W_HALF,   64'hFFFF_7FFF_0001_8000, 64'h0001_0001_FFFF_8000,
                64'h0000_8000_0000_0000, 1'b0);
        add_vec(OP_VSUB,  W_BYTE,   64'h0000_1080_FF00_0505, 64'h0100_2001_0001_0506,
                64'hFF00_F07F_FFFF_00FF, 1'b0);
        add_vec(OP_VSUB,  W_HALF,   64'h0000_1234_8000_FFFF, 64'h0001_0234_0001_FFFF,
                64'hFFFF_1000_7FFF_0000, 1'b0);
        // shift amounts use only the low bits of each b element
        add_vec(OP_VSLL,  W_BYTE,   64'hFFFF_8181_0101_F00F, 64'h0109_0203_0807_FF00,
                64'hFEFE_0408_0180_000F, 1'b0);
        add_vec(OP_VSRL,  W_HALF,   64'hFFFF_8000_1234_ABCD, 64'h0001_0014_000F_0004,
                64'h7FFF_0800_0000_0ABC, 1'b0);
        add_vec(OP_VSLL,  W_HALF,   64'h0001_00FF_8001_1234, 64'h0010_0008_0001_0011,
                64'h0001_FF00_0002_2468, 1'b0);
        add_vec(OP_VSRL,  W_BYTE,   64'h80FF_1234_F0F0_0101, 64'h0708_0109_0304_0000,
                64'h01FF_091A_1E0F_0101, 1'b0);
        add_vec(OP_VRTTH, W_BYTE,   64'h1234_5678_9ABC_DEF0, '0, 64'h2143_6587_A9CB_ED0F, 1'b0);
        add_vec(OP_VRTTH, W_HALF,   64'h1234_5678_9ABC_DEF0, '0, 64'h3412_7856_BC9A_F0DE, 1'b0);
        // byte products, even = upper byte of each pair
        add_vec(OP_VMULEU, W_BYTE,  64'hFF01_0203_1000_8080, 64'hFF02_0405_1000_0202,
                64'hFE01_0008_0100_0100, 1'b0);
        add_vec(OP_VMULOU, W_BYTE,  64'hFF01_0203_1000_8080, 64'hFF02_0405_1000_0202,
                64'h0002_000F_0000_0100, 1'b0);
        add_vec(OP_VSQEU, W_BYTE,   64'hFF01_0203_1000_8080, '0, 64'hFE01_0004_0100_4000, 1'b0);
        add_vec(OP_VSQOU, W_BYTE,   64'hFF01_0203_1000_8080, '0, 64'h0001_0009_0000_4000, 1'b0);
        // dropped functions and widths read as zero
        add_vec(OP_VDIV,   W_BYTE,   ALL1, PAT, '0, 1'b1);
        add_vec(OP_VMOD,   W_HALF,   ALL1, PAT, '0, 1'b1);
        add_vec(OP_VSQRT,  W_BYTE,   ALL1, PAT, '0, 1'b1);
        add_vec(OP_VSRA,   W_BYTE,   ALL1, PAT, '0, 1'b1);
        add_vec(OP_VNOP,   W_BYTE,   ALL1, PAT, '0, 1'b1);
        add_vec(OP_VADD,   W_WORD,   ALL1, PAT, '0, 1'b1);
        add_vec(OP_VSLL,   W_DOUBLE, ALL1, PAT, '0, 1'b1);
        add_vec(OP_VRTTH,  W_WORD,   ALL1, PAT, '0, 1'b1);
        add_vec(OP_VMULEU, W_HALF,   ALL1, PAT, '0, 1'b1);
        add_vec(OP_VSQOU,  W_HALF,   ALL1, PAT, '0, 1'b1);
        add_vec(OP_VMULOU, W_WORD,   ALL1, PAT, '0, 1'b1);
        add_vec(alu_op_e'(6'd30), W_BYTE, ALL1, PAT, '0, 1'b1);  // unused code
    endtask

    initial begin : main_seq
        alu_op_e     op;
        width_e      w;
        logic [63:0] ra;
        logic [63:0] rb;
        logic [64:0] exp_v;
        void'($urandom(6364));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        alu_op   = OP_VNOP;
        width    = W_BYTE;
        opnd     = '0;
        fill_table();
        max_cycles = vec_tab.size() + NUM_RAND + 20;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        foreach (vec_tab[i]) begin  // back to back, one per cycle
            issue_op(vec_tab[i].op, vec_tab[i].w, vec_tab[i].a, vec_tab[i].b,
                     vec_tab[i].y, vec_tab[i].bad);
        end
        go_idle(4);  // out_valid must drop here
        for (int n = 0; n < NUM_RAND; n++) begin
            op    = alu_op_e'(6'($urandom_range(1, 23)));
            w     = width_e'(2'($urandom_range(0, 3)));
            ra    = {$urandom, $urandom};
            rb    = {$urandom, $urandom};
            exp_v = model_result(op, w, ra, rb);
            issue_op(op, w, ra, rb, exp_v[63:0], exp_v[64]);
        end
        go_idle(1);
        while (due_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // ****************************************
    // output checks, on the falling edge
    // ****************************************
    always @(negedge clk) begin : check_out
        logic [64:0] exp_v;
        int          due_v;
        if (!rst_n && cycle > 0 && out_valid !== 1'b0) begin
            $display("Error: time %0t, out_valid expected 0 actual %b", $time, out_valid);
            errors++;
        end
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("out_valid went high at %0t with no operation in flight", $time);
                errors++;
            end else begin
                exp_v = exp_q.pop_front();
                due_v = due_q.pop_front();
                if (cycle != due_v) begin
                    $display("result at %0t came on cycle %0d instead of cycle %0d",
                             $time, cycle, due_v);
                    errors++;
                end
                if (result !== exp_v[63:0]) begin
                    $display("Error: time %0t, result expected %h actual %h",
                             $time, exp_v[63:0], result);
                    errors++;
                end
                if (illegal !== exp_v[64]) begin
                    $display("Error: time %0t, illegal expected %b actual %b",
                             $time, exp_v[64], illegal);
                    errors++;
                end
            end
        end else if (due_q.size() != 0 && cycle >= due_q[0]) begin
            $display("result due on cycle %0d never appeared (time %0t)", due_q[0], $time);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
            errors++;
        end
    end

    // cycle count and watchdog
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("errors: %0d", errors);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== simd_alu.f ====
hw/simd_alu_pkg.sv
hw/simd_op_decode.sv
hw/simd_lane.sv
hw/simd_result_merge.sv
hw/simd_alu_top.sv
test/simd_alu_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := simd_alu_tb
RTL_TOP   := simd_alu_top
FLIST     := simd_alu.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Verification passed
FAIL_MSG  := Verification failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
